//--- lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// BR with nzp = 000, never taken
// decode sees this while the IF slot is empty
`define LC3B_NOP 16'h0000

// architectural register count, R0 to R7
`define LC3B_NUM_REGS 8

// data and address width
`define LC3B_WORD_W 16

`endif

//--- lc3b_isa_pkg.sv
`include "lc3b_consts.svh"

package lc3b_isa_pkg;

	// one data or address word
	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

	// register index as found in the instruction fields
	typedef logic [2:0] lc3b_reg;

	// condition codes, bit 2 is N, bit 1 is Z, bit 0 is P
	// also the shape of the BR mask in instr[11:9]
	typedef logic [2:0] lc3b_nzp;

	// instr[15:12]
	// only the supported subset is named
	// anything else decodes as a NOP
	typedef enum logic [3:0] {
		// conditional branch, nzp = 000 is the NOP
		op_br  = 4'b0000,
		// register or imm5 form
		op_add = 4'b0001,
		op_and = 4'b0101,
		// base plus offset6 times two
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		// only the register form, low bits are all ones
		op_not = 4'b1001,
		// pc plus offset9 times two
		op_lea = 4'b1110
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

//--- lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

	import lc3b_isa_pkg::*;

	// function applied in the ALU unit
	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		// ignores operand b
		alu_not,
		// hands out the pc-relative sum, used by LEA and BR
		alu_pass
	} lc3b_aluop;

	// where the register write data comes from
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		// no register write
		wb_none
	} lc3b_wbsrc;

	// one per instruction, built in decode and carried to writeback
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop  aluop;
		// imm over sr2 for operand b
		logic       alu_imm;
		logic       mem_read;
		logic       mem_write;
		logic       load_regfile;
		logic       load_cc;
		logic       is_branch;
		// branch mask, zero for everything but BR
		lc3b_nzp    nzp;
		lc3b_wbsrc  wbsrc;
	} lc3b_control_word;

endpackage : lc3b_ctrl_pkg

//--- lc3b_pipe_ifs.sv
`timescale 1ns/1ps

// instruction leaving decode for the execute units
interface lc3b_issue_if
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
();

	logic             valid;
	lc3b_control_word ctrl;
	// already incremented by two
	lc3b_word         pc;
	lc3b_reg          dest;
	lc3b_word         sr1_val;
	// holds the dest register for STR
	lc3b_word         sr2_val;
	// imm5, offset6 or offset9, sign extended and scaled
	lc3b_word         imm;

	modport issuer (
		output valid, ctrl, pc, dest, sr1_val, sr2_val, imm
	);

	modport exec (
		input valid, ctrl, pc, dest, sr1_val, sr2_val, imm
	);

endinterface : lc3b_issue_if

// results from writeback back to fetch and decode
interface lc3b_wb_if
	import lc3b_isa_pkg::*;
();

	logic     reg_we;
	lc3b_reg  reg_dest;
	lc3b_word reg_data;
	// taken branch, fetch restarts at target
	logic     redirect;
	lc3b_word target;

	modport source (
		output reg_we, reg_dest, reg_data, redirect, target
	);

	modport sink (
		input reg_we, reg_dest, reg_data, redirect, target
	);

endinterface : lc3b_wb_if

//--- lc3b_fetch_decode.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_fetch_decode
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         instruction_response,
	input  lc3b_word     instr,
	input  logic         mem_ready,
	output lc3b_word     instruction_address,
	output logic         instruction_request,
	output logic         advance,
	lc3b_issue_if.issuer iss,
	lc3b_wb_if.sink      wb
);

	lc3b_word         pc;
	lc3b_word         pc_plus2;
	logic             fetch_en;
	logic             if_full;
	lc3b_word         if_instr;
	lc3b_word         dec_instr;
	lc3b_opcode       dec_op;
	lc3b_control_word dec_ctrl;
	lc3b_word         dec_imm;
	lc3b_reg          sr2_sel;
	lc3b_word         regs [`LC3B_NUM_REGS];

	// pc only moves on advance, so it still points at the IF slot's instruction
	assign pc_plus2 = pc + 16'd2;
	assign instruction_address = pc;
	// ask whenever the slot is empty, starting the cycle after reset
	assign instruction_request = fetch_en && !if_full;
	// every stage ready, pipeline moves as one
	assign advance = if_full && mem_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `LC3B_RESET_PC;
			fetch_en <= 1'b0;
			if_full <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			if (advance) begin
				pc <= wb.redirect ? wb.target : pc_plus2;
				if_full <= 1'b0;
			end else if (instruction_request && instruction_response) begin
				if_full <= 1'b1;
			end
		end
	end

	// IF slot payload
	always_ff @(posedge clk) begin
		if (instruction_request && instruction_response)
			if_instr <= instr;
	end

	// empty slot decodes as a NOP
	assign dec_instr = if_full ? if_instr : `LC3B_NOP;
	assign dec_op = lc3b_opcode'(dec_instr[15:12]);
	// STR reads its source through the second port
	assign sr2_sel = (dec_op == op_str) ? dec_instr[11:9] : dec_instr[2:0];

	// control ROM
	always_comb begin
		dec_ctrl = '0;
		dec_ctrl.opcode = dec_op;
		dec_ctrl.aluop = alu_add;
		dec_ctrl.wbsrc = wb_none;
		// imm5 unless overridden below
		dec_imm = {{11{dec_instr[4]}}, dec_instr[4:0]};
		case (dec_op)
			op_add, op_and: begin
				dec_ctrl.aluop = (dec_op == op_and) ? alu_and : alu_add;
				dec_ctrl.alu_imm = dec_instr[5];
				dec_ctrl.load_regfile = 1'b1;
				dec_ctrl.load_cc = 1'b1;
				dec_ctrl.wbsrc = wb_alu;
			end
			op_not: begin
				dec_ctrl.aluop = alu_not;
				dec_ctrl.load_regfile = 1'b1;
				dec_ctrl.load_cc = 1'b1;
				dec_ctrl.wbsrc = wb_alu;
			end
			op_ldr, op_str: begin
				// word offset in bytes
				dec_imm = {{9{dec_instr[5]}}, dec_instr[5:0], 1'b0};
				dec_ctrl.mem_read = (dec_op == op_ldr);
				dec_ctrl.mem_write = (dec_op == op_str);
				dec_ctrl.load_regfile = (dec_op == op_ldr);
				dec_ctrl.load_cc = (dec_op == op_ldr);
				dec_ctrl.wbsrc = (dec_op == op_ldr) ? wb_mem : wb_none;
			end
			op_lea: begin
				dec_imm = {{6{dec_instr[8]}}, dec_instr[8:0], 1'b0};
				dec_ctrl.aluop = alu_pass;
				// LC-3b LEA leaves the condition codes alone
				dec_ctrl.load_regfile = 1'b1;
				dec_ctrl.wbsrc = wb_alu;
			end
			op_br: begin
				dec_imm = {{6{dec_instr[8]}}, dec_instr[8:0], 1'b0};
				dec_ctrl.aluop = alu_pass;
				dec_ctrl.is_branch = 1'b1;
				dec_ctrl.nzp = dec_instr[11:9];
			end
			default: begin
				// unsupported, behaves as a NOP
				dec_ctrl.opcode = op_br;
			end
		endcase
	end

	// register file, write lands on the advance that retires the instruction
	always_ff @(posedge clk) begin
		if (advance && wb.reg_we)
			regs[wb.reg_dest] <= wb.reg_data;
	end

	// issue register control, squashed by a taken branch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iss.valid <= 1'b0;
			iss.ctrl <= '0;
		end else if (advance) begin
			iss.valid <= !wb.redirect;
			if (wb.redirect)
				iss.ctrl <= '0;
			else
				iss.ctrl <= dec_ctrl;
		end
	end

	// issue register payload
	always_ff @(posedge clk) begin
		if (advance) begin
			iss.pc <= pc_plus2;
			iss.dest <= dec_instr[11:9];
			iss.sr1_val <= regs[dec_instr[8:6]];
			iss.sr2_val <= regs[sr2_sel];
			iss.imm <= dec_imm;
		end
	end

	// pending fetch keeps its address until answered
	fetch_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		instruction_request && !instruction_response |=> $stable(instruction_address));

endmodule : lc3b_fetch_decode

//--- lc3b_alu_unit.sv
`timescale 1ns/1ps

module lc3b_alu_unit
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	lc3b_issue_if.exec iss,
	output lc3b_word   alu_result,
	output lc3b_word   br_target
);

	lc3b_word opnd_b;

	// imm5 or sr2
	assign opnd_b = iss.ctrl.alu_imm ? iss.imm : iss.sr2_val;

	// pc already points past the branch
	// imm holds offset9 scaled to bytes
	assign br_target = iss.pc + iss.imm;

	always_comb begin
		case (iss.ctrl.aluop)
			alu_add: begin
				alu_result = iss.sr1_val + opnd_b;
			end
			alu_and: begin
				alu_result = iss.sr1_val & opnd_b;
			end
			alu_not: begin
				alu_result = ~iss.sr1_val;
			end
			alu_pass: begin
				// LEA result is the branch adder output
				alu_result = br_target;
			end
			default: begin
				alu_result = iss.sr1_val;
			end
		endcase
	end

	// decode never hands a load to the ALU result path
	alu_no_load: assert property (@(posedge clk) disable iff (!arst_n)
		iss.valid && iss.ctrl.wbsrc == wb_alu |-> !iss.ctrl.mem_read);

endmodule : lc3b_alu_unit

//--- lc3b_mem_unit.sv
`timescale 1ns/1ps

module lc3b_mem_unit
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       advance,
	input  lc3b_word   mem_rdata,
	input  logic       data_response,
	lc3b_issue_if.exec iss,
	output lc3b_word   mem_address,
	output lc3b_word   write_data,
	output lc3b_word   load_data,
	output logic       data_request,
	output logic       write_enable,
	output logic       mem_ready
);

	// mem_wait means the access finished and the unit waits for advance
	typedef enum logic {
		mem_idle,
		mem_wait
	} mem_state_e;

	mem_state_e state;
	logic       access;

	assign access = iss.valid && (iss.ctrl.mem_read || iss.ctrl.mem_write);

	// base plus scaled offset
	assign mem_address = iss.sr1_val + iss.imm;
	// STR source came through read port two
	assign write_data = iss.sr2_val;

	// request held from the first cycle of the access until the response
	assign data_request = access && (state == mem_idle);
	assign write_enable = data_request && iss.ctrl.mem_write;
	// non-memory instructions never hold the pipe
	assign mem_ready = !access || (state == mem_wait);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_idle;
		end else begin
			case (state)
				mem_idle: begin
					if (data_request && data_response)
						state <= mem_wait;
				end
				mem_wait: begin
					// next instruction enters the issue slot
					if (advance)
						state <= mem_idle;
				end
				default: begin
					state <= mem_idle;
				end
			endcase
		end
	end

	// load word, held for writeback until the advance
	always_ff @(posedge clk) begin
		if (data_request && data_response && iss.ctrl.wbsrc == wb_mem)
			load_data <= mem_rdata;
	end

	// issue slot holds during back-pressure, so the request does too
	req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		data_request && !data_response |=> data_request && $stable(write_enable)
		&& $stable(mem_address) && $stable(write_data));

	// only a STR out of decode writes memory
	we_is_store: assert property (@(posedge clk) disable iff (!arst_n)
		write_enable |-> data_request && iss.ctrl.opcode == op_str);

	// word accesses only
	addr_even: assert property (@(posedge clk) disable iff (!arst_n)
		data_request |-> !mem_address[0]);

endmodule : lc3b_mem_unit

//--- lc3b_writeback.sv
`timescale 1ns/1ps

module lc3b_writeback
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       advance,
	input  lc3b_word   alu_result,
	input  lc3b_word   br_target,
	input  lc3b_word   load_data,
	lc3b_issue_if.exec iss,
	lc3b_wb_if.source  wb
);

	logic             ex_valid;
	lc3b_control_word ex_ctrl;
	lc3b_reg          ex_dest;
	lc3b_word         ex_alu;
	lc3b_word         ex_load;
	lc3b_word         ex_target;
	lc3b_nzp          cc;
	lc3b_nzp          cc_new;

	// EX/WB control, the instruction behind a taken branch is dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_ctrl <= '0;
		end else if (advance) begin
			ex_valid <= iss.valid && !wb.redirect;
			ex_ctrl <= iss.ctrl;
		end
	end

	// EX/WB payload
	always_ff @(posedge clk) begin
		if (advance) begin
			ex_dest <= iss.dest;
			ex_alu <= alu_result;
			ex_load <= load_data;
			ex_target <= br_target;
		end
	end

	assign wb.reg_we = ex_valid && ex_ctrl.load_regfile;
	assign wb.reg_dest = ex_dest;
	assign wb.reg_data = (ex_ctrl.wbsrc == wb_mem) ? ex_load : ex_alu;

	// n z p from the value being written
	assign cc_new = {wb.reg_data[15], wb.reg_data == 16'h0000,
		!wb.reg_data[15] && wb.reg_data != 16'h0000};

	// NZP register, starts at Z
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cc <= 3'b010;
		else if (advance && ex_valid && ex_ctrl.load_cc)
			cc <= cc_new;
	end

	// taken when the mask meets the current codes
	assign wb.redirect = ex_valid && ex_ctrl.is_branch && |(ex_ctrl.nzp & cc);
	assign wb.target = ex_target;

endmodule : lc3b_writeback

//--- lc3b_core.sv
`timescale 1ns/1ps

module lc3b_core
	import lc3b_isa_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  lc3b_word instr,
	input  logic     instruction_response,
	input  lc3b_word mem_rdata,
	input  logic     data_response,
	output lc3b_word instruction_address,
	output logic     instruction_request,
	output lc3b_word mem_address,
	output lc3b_word write_data,
	output logic     data_request,
	output logic     write_enable
);

	lc3b_word alu_result;
	lc3b_word br_target;
	lc3b_word load_data;
	logic     mem_ready;
	logic     advance;

	// decode to execute
	lc3b_issue_if iss_if ();
	// writeback to register file and pc
	lc3b_wb_if    wb_if ();

	lc3b_fetch_decode fetch_decode_i (
		.clk,
		.arst_n,
		.instruction_response,
		.instr,
		.mem_ready,
		.instruction_address,
		.instruction_request,
		.advance,
		.iss (iss_if),
		.wb  (wb_if)
	);

	lc3b_alu_unit alu_unit_i (
		.clk,
		.arst_n,
		.iss (iss_if),
		.alu_result,
		.br_target
	);

	lc3b_mem_unit mem_unit_i (
		.clk,
		.arst_n,
		.advance,
		.mem_rdata,
		.data_response,
		.iss (iss_if),
		.mem_address,
		.write_data,
		.load_data,
		.data_request,
		.write_enable,
		.mem_ready
	);

	lc3b_writeback writeback_i (
		.clk,
		.arst_n,
		.advance,
		.alu_result,
		.br_target,
		.load_data,
		.iss (iss_if),
		.wb  (wb_if)
	);

endmodule : lc3b_core

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset released on a falling edge, away from the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule : tb_clkgen

//--- tb_lc3b_core.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module tb_lc3b_core
	import lc3b_isa_pkg::*;
();

	localparam int MAX_DELAY = 4;
	localparam int MAX_STORES = 32;
	localparam lc3b_word DATA_BASE = 16'h0100;

	logic     clk;
	logic     arst_n;
	lc3b_word instr = '0;
	logic     instruction_response = 1'b0;
	lc3b_word mem_rdata = '0;
	logic     data_response = 1'b0;
	lc3b_word instruction_address;
	logic     instruction_request;
	lc3b_word mem_address;
	lc3b_word write_data;
	logic     data_request;
	logic     write_enable;

	lc3b_word    imem [512];
	lc3b_word    dmem [256];
	lc3b_word    gmem [256];
	lc3b_word    exp_addr [MAX_STORES];
	lc3b_word    exp_data [MAX_STORES];
	int          n_exp = 0;
	int          store_idx = 0;
	int          prog_len = 0;
	int          n_instr = 0;
	int          errors = 0;
	int unsigned i_wait = 0;
	int unsigned d_wait = 0;
	logic        fetched_any = 1'b0;
	logic        mem_op_fetched = 1'b0;
	logic        store_fire;

	tb_clkgen clkgen_i (
		.clk,
		.arst_n
	);

	lc3b_core dut_i (
		.clk,
		.arst_n,
		.instr,
		.instruction_response,
		.mem_rdata,
		.data_response,
		.instruction_address,
		.instruction_request,
		.mem_address,
		.write_data,
		.data_request,
		.write_enable
	);

	// data fill where every address bit matters
	function automatic lc3b_word fill_word(input int idx);
		lc3b_word a;
		a = idx[15:0];
		return (a * 16'h2f1b) ^ {a[7:0], a[15:8]} ^ 16'hc35a;
	endfunction

	// append one instruction and its three NOPs
	task automatic emit(input lc3b_word w);
		imem[prog_len] = w;
		imem[prog_len + 1] = `LC3B_NOP;
		imem[prog_len + 2] = `LC3B_NOP;
		imem[prog_len + 3] = `LC3B_NOP;
		prog_len += 4;
		n_instr++;
	endtask

	function automatic lc3b_word op_rr(input logic [3:0] op, input int d, input int s1,
		input int s2);
		return {op, d[2:0], s1[2:0], 3'b000, s2[2:0]};
	endfunction

	function automatic lc3b_word op_ri(input logic [3:0] op, input int d, input int s1,
		input int imm);
		return {op, d[2:0], s1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word op_mem(input logic [3:0] op, input int r, input int base,
		input int off);
		return {op, r[2:0], base[2:0], off[5:0]};
	endfunction

	// branch over its own NOPs and k emitted instructions
	task automatic emit_br(input logic [2:0] nzp, input int k);
		int off;
		off = 3 + 4 * k;
		emit({4'b0000, nzp, off[8:0]});
	endtask

	// LEA pointing at an absolute byte address
	task automatic emit_lea(input int d, input int addr);
		int off;
		off = (addr - (prog_len * 2 + 2)) / 2;
		emit({4'b1110, d[2:0], off[8:0]});
	endtask

	task automatic build_program();
		for (int i = 0; i < 512; i++)
			imem[i] = `LC3B_NOP;
		emit(op_ri(4'b0101, 0, 0, 0));
		emit(op_ri(4'b0101, 1, 1, 0));
		emit(op_ri(4'b0001, 1, 0, 7));
		emit(op_ri(4'b0001, 2, 1, -3));
		emit_lea(6, DATA_BASE);
		emit(op_mem(4'b0111, 1, 6, 0));
		emit(op_rr(4'b0001, 3, 1, 2));
		emit(op_mem(4'b0111, 3, 6, 1));
		emit(op_rr(4'b0101, 4, 3, 1));
		emit(op_mem(4'b0111, 4, 6, 2));
		emit(op_ri(4'b0101, 5, 3, -6));
		emit(op_mem(4'b0111, 5, 6, 3));
		emit({4'b1001, 3'd5, 3'd3, 6'b111111});
		emit(op_mem(4'b0111, 5, 6, 4));
		emit({4'b1110, 3'd7, 9'd5});
		emit(op_mem(4'b0111, 7, 6, 5));
		// preloaded word from the fill
		emit(op_mem(4'b0110, 0, 6, 20));
		emit(op_mem(4'b0111, 0, 6, 6));
		// zero result sets Z
		emit(op_ri(4'b0001, 2, 1, -7));
		emit_br(3'b010, 1);
		emit(op_mem(4'b0111, 2, 6, 7));
		emit(op_mem(4'b0111, 1, 6, 8));
		emit_br(3'b101, 1);
		emit(op_mem(4'b0111, 1, 6, 9));
		// negative result
		emit({4'b1001, 3'd3, 3'd1, 6'b111111});
		emit_br(3'b100, 1);
		emit(op_mem(4'b0111, 3, 6, 10));
		emit(op_mem(4'b0111, 3, 6, 11));
		emit_br(3'b011, 1);
		emit(op_mem(4'b0111, 1, 6, 12));
		// positive result
		emit(op_ri(4'b0001, 4, 1, 1));
		emit_br(3'b001, 1);
		emit(op_mem(4'b0111, 4, 6, 13));
		emit(op_mem(4'b0111, 4, 6, 14));
		emit_br(3'b110, 1);
		emit(op_mem(4'b0111, 4, 6, 15));
		// park in a self loop
		emit({4'b0000, 3'b111, 9'h1ff});
	endtask

	// reference model straight from the ISA
	task automatic run_golden();
		lc3b_word r [8];
		logic [2:0] cc;
		int pc;
		lc3b_word ir;
		lc3b_word b;
		lc3b_word res;
		lc3b_word addr;
		lc3b_word off6;
		lc3b_word off9;
		logic wr;
		cc = 3'b010;
		pc = `LC3B_RESET_PC;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		for (int step = 0; step < 4096; step++) begin
			ir = imem[(pc >> 1) & 511];
			pc += 2;
			off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
			off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			wr = 1'b1;
			res = '0;
			addr = r[ir[8:6]] + off6;
			case (ir[15:12])
				4'b0001: res = r[ir[8:6]] + b;
				4'b0101: res = r[ir[8:6]] & b;
				4'b1001: res = ~r[ir[8:6]];
				4'b0110: res = gmem[addr[8:1]];
				4'b1110: begin
					r[ir[11:9]] = pc[15:0] + off9;
					wr = 1'b0;
				end
				4'b0111: begin
					gmem[addr[8:1]] = r[ir[11:9]];
					exp_addr[n_exp] = addr;
					exp_data[n_exp] = r[ir[11:9]];
					n_exp++;
					wr = 1'b0;
				end
				default: begin
					wr = 1'b0;
					if (|(ir[11:9] & cc)) begin
						// the self loop ends the program
						if (pc[15:0] + off9 == pc[15:0] - 16'd2)
							return;
						pc = pc[15:0] + off9;
					end
				end
			endcase
			if (wr) begin
				r[ir[11:9]] = res;
				cc = {res[15], res == 16'h0000, !res[15] && res != 16'h0000};
			end
		end
	endtask

	assign store_fire = data_request && data_response && write_enable;

	// instruction memory answering after a random wait
	always @(posedge clk) begin
		instruction_response <= 1'b0;
		if (instruction_request && !instruction_response) begin
			if (i_wait == 0) begin
				instruction_response <= 1'b1;
				instr <= imem[instruction_address[9:1]];
				i_wait <= $urandom % (MAX_DELAY + 1);
			end else begin
				i_wait <= i_wait - 1;
			end
		end
		if (instruction_request && instruction_response)
			fetched_any <= 1'b1;
		// first LDR or STR has reached the IF slot
		if (instruction_request && instruction_response
			&& (instr[15:12] == 4'b0110 || instr[15:12] == 4'b0111))
			mem_op_fetched <= 1'b1;
	end

	// data memory with the same wait scheme
	always @(posedge clk) begin
		data_response <= 1'b0;
		if (data_request && !data_response) begin
			if (d_wait == 0) begin
				data_response <= 1'b1;
				mem_rdata <= dmem[mem_address[8:1]];
				d_wait <= $urandom % (MAX_DELAY + 1);
			end else begin
				d_wait <= d_wait - 1;
			end
		end
		if (store_fire) begin
			dmem[mem_address[8:1]] <= write_data;
			store_idx <= store_idx + 1;
		end
	end

	first_fetch_addr: assert property (@(posedge clk) disable iff (!arst_n)
		instruction_request && !fetched_any |-> instruction_address == `LC3B_RESET_PC)
		else begin
			errors++;
			$display("[ERROR] first_fetch_addr: expected %h, actual %h",
				`LC3B_RESET_PC, $sampled(instruction_address));
		end

	// no data traffic before the first load or store is fetched
	quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		!mem_op_fetched |-> !data_request && !write_enable)
		else begin
			errors++;
			$display("data port active before any load or store was fetched");
		end

	data_port_stable: assert property (@(posedge clk) disable iff (!arst_n)
		data_request && !data_response |=> $stable(mem_address) && $stable(write_data))
		else begin
			errors++;
			$display("data address or write data changed while a request was pending");
		end

	extra_store: assert property (@(posedge clk) disable iff (!arst_n)
		store_fire |-> store_idx < n_exp)
		else begin
			errors++;
			$display("store %0d happened, the program makes only %0d",
				$sampled(store_idx), n_exp);
		end

	store_addr: assert property (@(posedge clk) disable iff (!arst_n)
		store_fire && store_idx < n_exp |-> mem_address == exp_addr[store_idx])
		else begin
			errors++;
			$display("[ERROR] store_addr %0d: expected %h, actual %h", $sampled(store_idx),
				exp_addr[$sampled(store_idx)], $sampled(mem_address));
		end

	store_data: assert property (@(posedge clk) disable iff (!arst_n)
		store_fire && store_idx < n_exp |-> write_data == exp_data[store_idx])
		else begin
			errors++;
			$display("[ERROR] store_data %0d: expected %h, actual %h", $sampled(store_idx),
				exp_data[$sampled(store_idx)], $sampled(write_data));
		end

	// watchdog scaled by program length and worst delay
	initial begin
		@(posedge arst_n);
		repeat (200 * n_instr * MAX_DELAY) @(posedge clk);
		$display("timeout: only %0d of %0d stores seen", store_idx, n_exp);
		$display("Verification failed");
		$finish;
	end

	initial begin
		void'($urandom(26));
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(i);
			gmem[i] = fill_word(i);
		end
		build_program();
		run_golden();
		@(posedge arst_n);
		while (store_idx < n_exp)
			@(posedge clk);
		// let the self loop spin so a late store still trips the assertions
		repeat (60) @(posedge clk);
		if (store_idx != n_exp) begin
			errors++;
			$display("[ERROR] store_count: expected %0d, actual %0d", n_exp, store_idx);
		end
		$display("errors: %0d, stores checked: %0d", errors, store_idx);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule : tb_lc3b_core

//--- src.f
+incdir+.
lc3b_isa_pkg.sv
lc3b_ctrl_pkg.sv
lc3b_pipe_ifs.sv
lc3b_fetch_decode.sv
lc3b_alu_unit.sv
lc3b_mem_unit.sv
lc3b_writeback.sv
lc3b_core.sv
tb_clkgen.sv
tb_lc3b_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_lc3b_core -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
